// File: design/ugen_pkg.sv
`default_nettype none

package ugen_pkg;

    // word geometry
    localparam int DATA_WIDTH = 32;
    localparam int WORD_WIDTH = 2 * DATA_WIDTH;

    // context memory and gate memory address widths
    localparam int CTX_ADDR_WIDTH  = 6;
    localparam int GATE_ADDR_WIDTH = 6;

    // qubit count and cx position width
    localparam int QBIT_WIDTH = 6;

    // fixed payload lengths, sparse length depends on qubit count
    localparam int unsigned DENSE_LEN = 5;
    localparam int unsigned CX_LEN    = 1;

    // control fsm state codes
    localparam int STATE_WIDTH = 3;
    localparam logic [STATE_WIDTH-1:0] ST_IDLE      = 3'd0;
    localparam logic [STATE_WIDTH-1:0] ST_COUNT     = 3'd1;
    localparam logic [STATE_WIDTH-1:0] ST_TYPE      = 3'd2;
    localparam logic [STATE_WIDTH-1:0] ST_WAIT_TYPE = 3'd3;
    localparam logic [STATE_WIDTH-1:0] ST_PAYLOAD   = 3'd4;
    localparam logic [STATE_WIDTH-1:0] ST_DRAIN     = 3'd5;
    localparam logic [STATE_WIDTH-1:0] ST_PAUSE     = 3'd6;

    // code 3 is unused
    typedef enum logic [1:0] {
        SPARSE = 2'd0,
        DENSE  = 2'd1,
        CX     = 2'd2
    } matrix_type_e;

    // label carried along with each read
    typedef enum logic [1:0] {
        KIND_COUNT   = 2'd0,
        KIND_TYPE    = 2'd1,
        KIND_PAYLOAD = 2'd2
    } word_kind_e;

    // word 0, matrix count in the low bits
    typedef struct packed {
        logic [WORD_WIDTH-CTX_ADDR_WIDTH-1:0] rsvd;
        logic [CTX_ADDR_WIDTH-1:0]            count;
    } hdr_view_t;

    // first word of every matrix
    typedef struct packed {
        logic [WORD_WIDTH-3:0] rsvd;
        matrix_type_e          mtype;
    } type_view_t;

    // single cx payload word, control in the upper half
    typedef struct packed {
        logic [DATA_WIDTH-1:0] ctrl;
        logic [DATA_WIDTH-1:0] target;
    } cx_view_t;

    typedef union packed {
        hdr_view_t  hdr;
        type_view_t typ;
        cx_view_t   cx;
    } ctx_word_u;

endpackage

`default_nettype wire

// File: design/ctx_fetch_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ctx_fetch_if;
    import ugen_pkg::*;

    // read request side
    logic       req;
    word_kind_e req_kind;

    // returned word, one cycle behind the memory strobe
    logic       rvalid;
    word_kind_e rkind;
    ctx_word_u  rword;

    // ctrl also needs rword for the matrix count in the header
    modport ctrl (output req, output req_kind, input rvalid, input rkind, input rword);
    modport fetch (input req, input req_kind, output rvalid, output rkind, output rword);
    // decoder watches the count request to load the qubit count
    modport decoder (input req, input req_kind, input rvalid, input rkind, input rword);
    modport emitter (input rvalid, input rkind, input rword);

endinterface

`default_nettype wire

// File: design/ctx_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module ctx_fetch (
    input  logic                                clk,
    input  logic                                rst_n,
    ctx_fetch_if.fetch                          fch,
    output logic                                o_ctx_en,
    output logic [ugen_pkg::CTX_ADDR_WIDTH-1:0] o_ctx_addr,
    input  logic [ugen_pkg::WORD_WIDTH-1:0]     i_ctx_rdata
);
    import ugen_pkg::*;

    // next address for non-header reads
    logic [CTX_ADDR_WIDTH-1:0] ptr_q;
    // kind of the read now on the memory port
    word_kind_e                kind_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr_q      <= '0;
            o_ctx_en   <= 1'b0;
            o_ctx_addr <= '0;
            kind_q     <= KIND_COUNT;
            fch.rvalid <= 1'b0;
            fch.rkind  <= KIND_COUNT;
        end else begin
            o_ctx_en   <= fch.req;
            // memory answers one cycle after the strobe
            fch.rvalid <= o_ctx_en;
            fch.rkind  <= kind_q;
            if (fch.req) begin
                kind_q <= fch.req_kind;
                if (fch.req_kind == KIND_COUNT) begin
                    // header always at word 0 so the walk restarts
                    o_ctx_addr <= '0;
                    ptr_q      <= CTX_ADDR_WIDTH'(1);
                end else begin
                    o_ctx_addr <= ptr_q;
                    ptr_q      <= ptr_q + 1'b1;
                end
            end
        end
    end

    // memory output register is the data stage
    assign fch.rword = i_ctx_rdata;

    // a returned word needs a strobe one cycle before
    a_rvalid_follows_en: assert property (
        @(posedge clk) disable iff (!rst_n) fch.rvalid |-> $past(o_ctx_en));

endmodule

`default_nettype wire

// File: design/matrix_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_decoder (
    input  logic                                 clk,
    input  logic                                 rst_n,
    ctx_fetch_if.decoder                         dec,
    input  logic [ugen_pkg::QBIT_WIDTH-1:0]      i_qbit_num,
    output ugen_pkg::matrix_type_e               o_matrix_type,
    output logic [ugen_pkg::GATE_ADDR_WIDTH-1:0] o_payload_len,
    output logic                                 o_type_ready,
    output logic [ugen_pkg::QBIT_WIDTH-1:0]      o_cx_ctrl_pos,
    output logic [ugen_pkg::QBIT_WIDTH-1:0]      o_cx_target_pos
);
    import ugen_pkg::*;

    // qubit count held for the whole circuit
    logic [QBIT_WIDTH-1:0]      qbit_num_q;
    logic                       count_req;
    logic                       type_ret;
    logic                       payload_ret;
    logic [GATE_ADDR_WIDTH-1:0] len_next;

    assign count_req   = dec.req && (dec.req_kind == KIND_COUNT);
    assign type_ret    = dec.rvalid && (dec.rkind == KIND_TYPE);
    assign payload_ret = dec.rvalid && (dec.rkind == KIND_PAYLOAD);

    // payload length from the returning type word
    always_comb begin
        case (dec.rword.typ.mtype)
            // 2n - 2 words
            SPARSE:  len_next = (GATE_ADDR_WIDTH'(qbit_num_q) << 1) - GATE_ADDR_WIDTH'(2);
            DENSE:   len_next = GATE_ADDR_WIDTH'(DENSE_LEN);
            default: len_next = GATE_ADDR_WIDTH'(CX_LEN);
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            qbit_num_q      <= '0;
            o_matrix_type   <= SPARSE;
            o_payload_len   <= '0;
            o_type_ready    <= 1'b0;
            o_cx_ctrl_pos   <= '0;
            o_cx_target_pos <= '0;
        end else begin
            o_type_ready <= type_ret;
            if (count_req) begin
                qbit_num_q <= i_qbit_num;
            end
            if (type_ret) begin
                o_matrix_type <= dec.rword.typ.mtype;
                o_payload_len <= len_next;
            end
            // cx carries positions, nothing else
            if (payload_ret && o_matrix_type == CX) begin
                o_cx_ctrl_pos   <= dec.rword.cx.ctrl[QBIT_WIDTH-1:0];
                o_cx_target_pos <= dec.rword.cx.target[QBIT_WIDTH-1:0];
            end
        end
    end

    // context image must only hold known type codes
    a_type_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        type_ret |-> (2'(dec.rword.typ.mtype) != 2'd3));

    // sparse length needs at least two qubits
    a_qbit_min: assert property (
        @(posedge clk) disable iff (!rst_n)
        count_req |=> (qbit_num_q >= QBIT_WIDTH'(2)));

endmodule

`default_nettype wire

// File: design/gate_emitter.sv
`timescale 1ns/1ps
`default_nettype none

module gate_emitter (
    input  logic                                 clk,
    input  logic                                 rst_n,
    ctx_fetch_if.emitter                         emt,
    input  ugen_pkg::matrix_type_e               i_matrix_type,
    output logic                                 o_gate_valid,
    output logic [ugen_pkg::GATE_ADDR_WIDTH-1:0] o_gate_addr,
    output logic [ugen_pkg::WORD_WIDTH-1:0]      o_gate
);
    import ugen_pkg::*;

    // next slot in the pe local memory
    logic [GATE_ADDR_WIDTH-1:0] addr_cnt_q;
    logic                       fwd;

    // only sparse and dense words go out
    assign fwd = emt.rvalid && (emt.rkind == KIND_PAYLOAD) && (i_matrix_type != CX);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_cnt_q   <= '0;
            o_gate_valid <= 1'b0;
        end else begin
            o_gate_valid <= fwd;
            // new matrix, start again at slot 0
            if (emt.rvalid && emt.rkind == KIND_TYPE) begin
                addr_cnt_q <= '0;
            end else if (fwd) begin
                addr_cnt_q <= addr_cnt_q + 1'b1;
            end
        end
    end

    // gate data and address, qualified by o_gate_valid
    always_ff @(posedge clk) begin
        if (fwd) begin
            o_gate      <= emt.rword;
            o_gate_addr <= addr_cnt_q;
        end
    end

    // decoder type must already be cx-free when a gate leaves
    a_no_gate_on_cx: assert property (
        @(posedge clk) disable iff (!rst_n) o_gate_valid |-> (i_matrix_type != CX));

endmodule

`default_nettype wire

// File: design/ugen_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ugen_ctrl (
    input  logic                                 clk,
    input  logic                                 rst_n,
    ctx_fetch_if.ctrl                            ctl,
    input  logic                                 i_start,
    input  logic                                 i_continue,
    input  logic [ugen_pkg::GATE_ADDR_WIDTH-1:0] i_payload_len,
    input  logic                                 i_type_ready,
    output logic                                 o_done_temporality,
    output logic                                 o_done
);
    import ugen_pkg::*;

    logic [STATE_WIDTH-1:0]     state_q;
    // matrices in the circuit, from word 0
    logic [CTX_ADDR_WIDTH-1:0]  mat_cnt_q;
    // matrix being streamed
    logic [CTX_ADDR_WIDTH-1:0]  mat_idx_q;
    // payload reads issued / returned for this matrix
    logic [GATE_ADDR_WIDTH-1:0] issue_cnt_q;
    logic [GATE_ADDR_WIDTH-1:0] ret_cnt_q;
    logic                       payload_ret;
    logic                       last_ret;
    logic                       last_mat;

    // read requests straight from the state
    always_comb begin
        ctl.req      = 1'b0;
        ctl.req_kind = KIND_TYPE;
        case (state_q)
            ST_COUNT: begin
                ctl.req      = 1'b1;
                ctl.req_kind = KIND_COUNT;
            end
            ST_TYPE: begin
                ctl.req      = 1'b1;
                ctl.req_kind = KIND_TYPE;
            end
            ST_PAYLOAD: begin
                ctl.req      = 1'b1;
                ctl.req_kind = KIND_PAYLOAD;
            end
            default: begin
                ctl.req = 1'b0;
            end
        endcase
    end

    assign payload_ret = ctl.rvalid && (ctl.rkind == KIND_PAYLOAD);
    assign last_ret    = payload_ret && (ret_cnt_q == i_payload_len - 1'b1);
    assign last_mat    = (mat_idx_q == mat_cnt_q - 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q            <= ST_IDLE;
            mat_cnt_q          <= '0;
            mat_idx_q          <= '0;
            issue_cnt_q        <= '0;
            ret_cnt_q          <= '0;
            o_done_temporality <= 1'b0;
            o_done             <= 1'b0;
        end else begin
            // pulses by default low
            o_done_temporality <= 1'b0;
            o_done             <= 1'b0;
            // header returns while waiting for the type
            if (ctl.rvalid && ctl.rkind == KIND_COUNT) begin
                mat_cnt_q <= ctl.rword.hdr.count;
            end
            if (payload_ret) begin
                ret_cnt_q <= ret_cnt_q + 1'b1;
            end
            case (state_q)
                ST_IDLE: begin
                    if (i_start) begin
                        state_q   <= ST_COUNT;
                        mat_idx_q <= '0;
                    end
                end
                ST_COUNT: begin
                    state_q <= ST_TYPE;
                end
                ST_TYPE: begin
                    state_q <= ST_WAIT_TYPE;
                end
                ST_WAIT_TYPE: begin
                    // length valid once the decoder flags it
                    if (i_type_ready) begin
                        state_q     <= ST_PAYLOAD;
                        issue_cnt_q <= '0;
                        ret_cnt_q   <= '0;
                    end
                end
                ST_PAYLOAD: begin
                    // back-to-back payload reads
                    issue_cnt_q <= issue_cnt_q + 1'b1;
                    if (issue_cnt_q == i_payload_len - 1'b1) begin
                        state_q <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    // up to two reads still in flight
                    if (last_ret) begin
                        o_done_temporality <= 1'b1;
                        mat_idx_q          <= mat_idx_q + 1'b1;
                        if (last_mat) begin
                            o_done  <= 1'b1;
                            state_q <= ST_IDLE;
                        end else begin
                            state_q <= ST_PAUSE;
                        end
                    end
                end
                ST_PAUSE: begin
                    // hold until the pe array asks for more
                    if (i_continue) begin
                        state_q <= ST_TYPE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // quiet states see no new reads and nothing left in the fetch pipe
    a_quiet_when_waiting: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_q == ST_IDLE || state_q == ST_PAUSE) |-> (!ctl.req && !ctl.rvalid));

endmodule

`default_nettype wire

// File: design/coo_matrix_generator.sv
`timescale 1ns/1ps
`default_nettype none

module coo_matrix_generator (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 i_start,
    input  logic                                 i_continue,
    input  logic [ugen_pkg::QBIT_WIDTH-1:0]      i_qbit_num,
    input  logic [ugen_pkg::WORD_WIDTH-1:0]      i_ctx_rdata,
    output logic                                 o_ctx_en,
    output logic [ugen_pkg::CTX_ADDR_WIDTH-1:0]  o_ctx_addr,
    output logic [1:0]                           o_matrix_type,
    output logic [ugen_pkg::QBIT_WIDTH-1:0]      o_cx_ctrl_pos,
    output logic [ugen_pkg::QBIT_WIDTH-1:0]      o_cx_target_pos,
    output logic                                 o_done_temporality,
    output logic                                 o_gate_valid,
    output logic [ugen_pkg::GATE_ADDR_WIDTH-1:0] o_gate_addr,
    output logic [ugen_pkg::WORD_WIDTH-1:0]      o_gate,
    output logic                                 o_done
);
    import ugen_pkg::*;

    // decoder to emitter and out to the pe array
    matrix_type_e               matrix_type;
    logic [GATE_ADDR_WIDTH-1:0] payload_len;
    logic                       type_ready;

    ctx_fetch_if fetch_bus ();

    assign o_matrix_type = matrix_type;

    ugen_ctrl ctrl_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .ctl                (fetch_bus.ctrl),
        .i_start            (i_start),
        .i_continue         (i_continue),
        .i_payload_len      (payload_len),
        .i_type_ready       (type_ready),
        .o_done_temporality (o_done_temporality),
        .o_done             (o_done)
    );

    ctx_fetch fetch_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .fch         (fetch_bus.fetch),
        .o_ctx_en    (o_ctx_en),
        .o_ctx_addr  (o_ctx_addr),
        .i_ctx_rdata (i_ctx_rdata)
    );

    matrix_decoder decoder_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .dec             (fetch_bus.decoder),
        .i_qbit_num      (i_qbit_num),
        .o_matrix_type   (matrix_type),
        .o_payload_len   (payload_len),
        .o_type_ready    (type_ready),
        .o_cx_ctrl_pos   (o_cx_ctrl_pos),
        .o_cx_target_pos (o_cx_target_pos)
    );

    gate_emitter emitter_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .emt           (fetch_bus.emitter),
        .i_matrix_type (matrix_type),
        .o_gate_valid  (o_gate_valid),
        .o_gate_addr   (o_gate_addr),
        .o_gate        (o_gate)
    );

endmodule

`default_nettype wire

// File: bench/tb_coo_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_coo_gen;
    import ugen_pkg::*;

    localparam int MDONE_TIMEOUT = 200;

    logic                       clk;
    logic                       rst_n;
    logic                       i_start;
    logic                       i_continue;
    logic [QBIT_WIDTH-1:0]      i_qbit_num;
    logic [WORD_WIDTH-1:0]      ctx_rdata;
    logic                       o_ctx_en;
    logic [CTX_ADDR_WIDTH-1:0]  o_ctx_addr;
    logic [1:0]                 o_matrix_type;
    logic [QBIT_WIDTH-1:0]      o_cx_ctrl_pos;
    logic [QBIT_WIDTH-1:0]      o_cx_target_pos;
    logic                       o_done_temporality;
    logic                       o_gate_valid;
    logic [GATE_ADDR_WIDTH-1:0] o_gate_addr;
    logic [WORD_WIDTH-1:0]      o_gate;
    logic                       o_done;

    // context memory image rebuilt per test
    logic [WORD_WIDTH-1:0] mem [0:63];
    int                    wr_ptr;

    // expected stream from the layout rules
    logic [WORD_WIDTH-1:0]      exp_data[$];
    logic [GATE_ADDR_WIDTH-1:0] exp_addr[$];
    logic [1:0]                 exp_type_q[$];
    logic [QBIT_WIDTH-1:0]      exp_ctrl_q[$];
    logic [QBIT_WIDTH-1:0]      exp_target_q[$];

    // what the monitor saw
    logic [WORD_WIDTH-1:0]      got_data[$];
    logic [GATE_ADDR_WIDTH-1:0] got_addr[$];
    int                         mdone_cnt;
    int                         done_cnt;
    // matrix-done count seen at the done pulse or 0 if apart
    int                         done_idx;

    coo_matrix_generator dut_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .i_start            (i_start),
        .i_continue         (i_continue),
        .i_qbit_num         (i_qbit_num),
        .i_ctx_rdata        (ctx_rdata),
        .o_ctx_en           (o_ctx_en),
        .o_ctx_addr         (o_ctx_addr),
        .o_matrix_type      (o_matrix_type),
        .o_cx_ctrl_pos      (o_cx_ctrl_pos),
        .o_cx_target_pos    (o_cx_target_pos),
        .o_done_temporality (o_done_temporality),
        .o_gate_valid       (o_gate_valid),
        .o_gate_addr        (o_gate_addr),
        .o_gate             (o_gate),
        .o_done             (o_done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // registered read port with data 1 ns after the edge
    always @(posedge clk) begin : mem_port
        logic                      en_s;
        logic [CTX_ADDR_WIDTH-1:0] addr_s;
        en_s   = o_ctx_en;
        addr_s = o_ctx_addr;
        #1;
        if (en_s) begin
            ctx_rdata = mem[addr_s];
        end
    end

    // outputs are flops and stable at the falling edge
    always @(negedge clk) begin
        if (o_gate_valid) begin
            got_data.push_back(o_gate);
            got_addr.push_back(o_gate_addr);
        end
        if (o_done_temporality) begin
            mdone_cnt++;
        end
        if (o_done) begin
            done_cnt++;
            done_idx = o_done_temporality ? mdone_cnt : 0;
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_equal(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("CHECK FAILED %s expected %0h actual %0h",
                                name, expected, actual));
        end
    endtask

    // fresh image with unused words tagged by address
    task automatic begin_circuit();
        int a;
        for (a = 0; a < 64; a++) begin
            mem[a] = {32'hface_0000 | 32'(a), 32'h0000_b0d0 ^ (32'(a) << 16)};
        end
        wr_ptr = 1;
        exp_data.delete();
        exp_addr.delete();
        exp_type_q.delete();
        exp_ctrl_q.delete();
        exp_target_q.delete();
    endtask

    // type word then payload with junk in the unused type bits
    task automatic add_matrix(input logic [1:0] mtype, input int n);
        logic [63:0] word;
        int          len;
        int          i;
        word      = {$urandom, $urandom};
        word[1:0] = mtype;
        mem[wr_ptr] = word;
        wr_ptr++;
        exp_type_q.push_back(mtype);
        if (mtype == 2'(SPARSE)) begin
            len = 2 * n - 2;
        end else if (mtype == 2'(DENSE)) begin
            len = 5;
        end else begin
            len = 1;
        end
        for (i = 0; i < len; i++) begin
            word = {$urandom, $urandom};
            mem[wr_ptr] = word;
            wr_ptr++;
            if (mtype == 2'(CX)) begin
                // control in the upper half and target in the lower
                exp_ctrl_q.push_back(word[32 +: QBIT_WIDTH]);
                exp_target_q.push_back(word[0 +: QBIT_WIDTH]);
            end else begin
                exp_data.push_back(word);
                exp_addr.push_back(GATE_ADDR_WIDTH'(i));
            end
        end
    endtask

    task automatic wait_matrix_done(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!o_done_temporality) begin
            if (cycles >= MDONE_TIMEOUT) begin
                abort_run($sformatf("%s: no matrix-done pulse within %0d cycles",
                                    name, MDONE_TIMEOUT));
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    // no reads and no gates while continue stays low
    task automatic hold_paused(input string name, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_equal({name, " pause ctx_en"}, 64'd0, 64'(o_ctx_en));
            check_equal({name, " pause gate_valid"}, 64'd0, 64'(o_gate_valid));
        end
    endtask

    task automatic run_circuit(input string name, input int n, input int pause_after,
                               input int pause_cycles);
        logic [63:0] hdr;
        int          count;
        int          cx_idx;
        int          m;
        int          i;
        count     = exp_type_q.size();
        cx_idx    = 0;
        hdr       = {$urandom, $urandom};
        hdr[5:0]  = 6'(count);
        mem[0]    = hdr;
        got_data.delete();
        got_addr.delete();
        mdone_cnt = 0;
        done_cnt  = 0;
        done_idx  = 0;
        @(posedge clk);
        #1;
        i_qbit_num = QBIT_WIDTH'(n);
        i_start    = 1'b1;
        @(posedge clk);
        #1;
        i_start = 1'b0;
        for (m = 0; m < count; m++) begin
            wait_matrix_done(name);
            check_equal({name, " type"}, 64'(exp_type_q[m]), 64'(o_matrix_type));
            if (exp_type_q[m] == 2'(CX)) begin
                check_equal({name, " cx ctrl"}, 64'(exp_ctrl_q[cx_idx]), 64'(o_cx_ctrl_pos));
                check_equal({name, " cx target"}, 64'(exp_target_q[cx_idx]),
                            64'(o_cx_target_pos));
                cx_idx++;
            end
            if (m < count - 1) begin
                if (m == pause_after) begin
                    hold_paused(name, pause_cycles);
                end
                @(posedge clk);
                #1;
                i_continue = 1'b1;
                @(posedge clk);
                #1;
                i_continue = 1'b0;
            end
        end
        // quiet tail where nothing more may arrive
        repeat (4) @(negedge clk);
        @(posedge clk);
        check_equal({name, " gate count"}, 64'(exp_data.size()), 64'(got_data.size()));
        for (i = 0; i < exp_data.size(); i++) begin
            check_equal($sformatf("%s gate %0d data", name, i), exp_data[i], got_data[i]);
            check_equal($sformatf("%s gate %0d addr", name, i), 64'(exp_addr[i]),
                        64'(got_addr[i]));
        end
        check_equal({name, " matrix-done count"}, 64'(count), 64'(mdone_cnt));
        check_equal({name, " done count"}, 64'd1, 64'(done_cnt));
        check_equal({name, " done with last matrix"}, 64'(count), 64'(done_idx));
    endtask

    task automatic test_reset();
        repeat (10) begin
            @(negedge clk);
            check_equal("reset ctx_en", 64'd0, 64'(o_ctx_en));
            check_equal("reset gate_valid", 64'd0, 64'(o_gate_valid));
            check_equal("reset matrix_done", 64'd0, 64'(o_done_temporality));
            check_equal("reset done", 64'd0, 64'(o_done));
        end
        check_equal("reset matrix_type", 64'd0, 64'(o_matrix_type));
        check_equal("reset cx ctrl", 64'd0, 64'(o_cx_ctrl_pos));
        check_equal("reset cx target", 64'd0, 64'(o_cx_target_pos));
    endtask

    initial begin
        void'($urandom(32'h38f1_57e9));
        mdone_cnt  = 0;
        done_cnt   = 0;
        done_idx   = 0;
        rst_n      = 1'b0;
        i_start    = 1'b0;
        i_continue = 1'b0;
        i_qbit_num = '0;
        ctx_rdata  = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset();

        // n = 4 gives six gates from words 2 to 7
        begin_circuit();
        add_matrix(2'(SPARSE), 4);
        run_circuit("sparse", 4, -1, 0);

        begin_circuit();
        add_matrix(2'(DENSE), 3);
        run_circuit("dense", 3, -1, 0);

        begin_circuit();
        add_matrix(2'(CX), 5);
        run_circuit("cx", 5, -1, 0);

        begin_circuit();
        add_matrix(2'(SPARSE), 3);
        add_matrix(2'(CX), 3);
        add_matrix(2'(DENSE), 3);
        run_circuit("mixed", 3, -1, 0);

        // 20 idle cycles after the first matrix
        begin_circuit();
        add_matrix(2'(DENSE), 4);
        add_matrix(2'(SPARSE), 4);
        run_circuit("pause", 4, 0, 20);

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
design/ugen_pkg.sv
design/ctx_fetch_if.sv
design/ctx_fetch.sv
design/matrix_decoder.sv
design/gate_emitter.sv
design/ugen_ctrl.sv
design/coo_matrix_generator.sv
bench/tb_coo_gen.sv

// File: run.sh
#!/bin/sh
# build and run the regression with verilator, exit status follows the testbench
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal \
        -f vlog.f --top-module tb_coo_gen \
    && ./obj_dir/Vtb_coo_gen \
    || { echo "simulation failed"; exit 1; }
